// File: hw/core_pkg.sv
package core_pkg;

  ////////////////////
  // instruction word
  ////////////////////

  // one word, two readings: register form and immediate form
  typedef union packed {
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [10:0] funct;
    } r;
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [15:0] imm;
    } i;
  } insn_word_u;

  // major opcodes, anything else decodes as a nop
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_XORI  = 6'h0e;
  localparam logic [5:0] OP_LUI   = 6'h0f;

  // r-format function codes in the low bits of funct
  localparam logic [10:0] FN_ADD = 11'd0;
  localparam logic [10:0] FN_SUB = 11'd1;
  localparam logic [10:0] FN_AND = 11'd2;
  localparam logic [10:0] FN_OR  = 11'd3;
  localparam logic [10:0] FN_XOR = 11'd4;
  localparam logic [10:0] FN_SLL = 11'd5;
  localparam logic [10:0] FN_SRL = 11'd6;
  localparam logic [10:0] FN_SLT = 11'd7;

  ////////////////////
  // alu operations
  ////////////////////

  localparam logic [3:0] ALU_ADD = 4'd0;
  localparam logic [3:0] ALU_SUB = 4'd1;
  localparam logic [3:0] ALU_AND = 4'd2;
  localparam logic [3:0] ALU_OR  = 4'd3;
  localparam logic [3:0] ALU_XOR = 4'd4;
  localparam logic [3:0] ALU_SLL = 4'd5;
  localparam logic [3:0] ALU_SRL = 4'd6;
  localparam logic [3:0] ALU_SLT = 4'd7;
  localparam logic [3:0] ALU_LUI = 4'd8;

  // pc, alu_op, wr_en, dest, rs1, rs2, src2_is_imm, imm
  localparam int UOP_W = 32 + 4 + 1 + 5 + 5 + 5 + 1 + 32;

  ////////////////////
  // instruction buffer
  ////////////////////

  localparam int IBUF_WAY_DEPTH = 8;
  localparam int IBUF_PTR_W     = $clog2(IBUF_WAY_DEPTH);
  localparam int IBUF_LEN_W     = IBUF_PTR_W + 2;
  // 16 entries less 2 arriving now and 2 held in decode
  localparam int IBUF_READY_MAX = 12;

endpackage

// File: hw/insn_decode.sv
`timescale 1ns/1ps

module insn_decode
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_flush,
  input  logic [1:0]  i_size,
  input  logic [31:0] i_a_pc,
  input  logic [31:0] i_a_insn,
  input  logic [31:0] i_b_pc,
  input  logic [31:0] i_b_insn,
  output logic [1:0]  o_size,
  output logic [31:0] o_a_pc,
  output logic [3:0]  o_a_alu_op,
  output logic        o_a_wr_en,
  output logic [4:0]  o_a_dest,
  output logic [4:0]  o_a_rs1,
  output logic [4:0]  o_a_rs2,
  output logic        o_a_src2_is_imm,
  output logic [31:0] o_a_imm,
  output logic [31:0] o_b_pc,
  output logic [3:0]  o_b_alu_op,
  output logic        o_b_wr_en,
  output logic [4:0]  o_b_dest,
  output logic [4:0]  o_b_rs1,
  output logic [4:0]  o_b_rs2,
  output logic        o_b_src2_is_imm,
  output logic [31:0] o_b_imm
);

  logic [3:0]  a_alu_op;
  logic        a_wr_en;
  logic [4:0]  a_rs1;
  logic [4:0]  a_rs2;
  logic        a_src2_is_imm;
  logic [31:0] a_imm;
  logic [3:0]  b_alu_op;
  logic        b_wr_en;
  logic [4:0]  b_rs1;
  logic [4:0]  b_rs2;
  logic        b_src2_is_imm;
  logic [31:0] b_imm;

  function automatic void decode_word(
    input  insn_word_u  w,
    output logic [3:0]  alu_op,
    output logic        wr_en,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic        src2_is_imm,
    output logic [31:0] imm
  );
    logic known;
    known       = 1'b1;
    alu_op      = ALU_ADD;
    src2_is_imm = (w.i.op != OP_RTYPE);
    rs1         = w.r.rs1;
    // immediate forms read no second register
    rs2         = src2_is_imm ? 5'd0 : w.r.rs2;
    imm         = {{16{w.i.imm[15]}}, w.i.imm};
    case (w.i.op)
      OP_RTYPE: begin
        case (w.r.funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SLT:  alu_op = ALU_SLT;
          default: known = 1'b0;
        endcase
      end
      OP_ADDI: alu_op = ALU_ADD;
      OP_ANDI: alu_op = ALU_AND;
      OP_ORI:  alu_op = ALU_OR;
      OP_XORI: alu_op = ALU_XOR;
      OP_LUI: begin
        alu_op = ALU_LUI;
        rs1    = 5'd0;
        imm    = {w.i.imm, 16'd0};
      end
      default: known = 1'b0;
    endcase
    // nops and writes to r0 never report
    wr_en = known && (w.r.rd != 5'd0);
  endfunction

  always_comb begin
    decode_word(i_a_insn, a_alu_op, a_wr_en, a_rs1, a_rs2, a_src2_is_imm, a_imm);
    decode_word(i_b_insn, b_alu_op, b_wr_en, b_rs1, b_rs2, b_src2_is_imm, b_imm);
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_flush) o_size <= 2'd0;
    else o_size <= i_size;
  end

  always_ff @(posedge clk) begin
    o_a_pc          <= i_a_pc;
    o_a_alu_op      <= a_alu_op;
    o_a_wr_en       <= a_wr_en;
    o_a_dest        <= i_a_insn[25:21];
    o_a_rs1         <= a_rs1;
    o_a_rs2         <= a_rs2;
    o_a_src2_is_imm <= a_src2_is_imm;
    o_a_imm         <= a_imm;
    o_b_pc          <= i_b_pc;
    o_b_alu_op      <= b_alu_op;
    o_b_wr_en       <= b_wr_en;
    o_b_dest        <= i_b_insn[25:21];
    o_b_rs1         <= b_rs1;
    o_b_rs2         <= b_rs2;
    o_b_src2_is_imm <= b_src2_is_imm;
    o_b_imm         <= b_imm;
  end

endmodule

// File: hw/insn_buffer.sv
`timescale 1ns/1ps

module insn_buffer
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_flush,
  input  logic [1:0]  i_size,
  input  logic [31:0] i_a_pc,
  input  logic [3:0]  i_a_alu_op,
  input  logic        i_a_wr_en,
  input  logic [4:0]  i_a_dest,
  input  logic [4:0]  i_a_rs1,
  input  logic [4:0]  i_a_rs2,
  input  logic        i_a_src2_is_imm,
  input  logic [31:0] i_a_imm,
  input  logic [31:0] i_b_pc,
  input  logic [3:0]  i_b_alu_op,
  input  logic        i_b_wr_en,
  input  logic [4:0]  i_b_dest,
  input  logic [4:0]  i_b_rs1,
  input  logic [4:0]  i_b_rs2,
  input  logic        i_b_src2_is_imm,
  input  logic [31:0] i_b_imm,
  input  logic [1:0]  i_take,
  output logic        o_ready,
  output logic        o_a_valid,
  output logic [31:0] o_a_pc,
  output logic [3:0]  o_a_alu_op,
  output logic        o_a_wr_en,
  output logic [4:0]  o_a_dest,
  output logic [4:0]  o_a_rs1,
  output logic [4:0]  o_a_rs2,
  output logic        o_a_src2_is_imm,
  output logic [31:0] o_a_imm,
  output logic        o_b_valid,
  output logic [31:0] o_b_pc,
  output logic [3:0]  o_b_alu_op,
  output logic        o_b_wr_en,
  output logic [4:0]  o_b_dest,
  output logic [4:0]  o_b_rs1,
  output logic [4:0]  o_b_rs2,
  output logic        o_b_src2_is_imm,
  output logic [31:0] o_b_imm
);

  logic [UOP_W-1:0]      way0 [IBUF_WAY_DEPTH];
  logic [UOP_W-1:0]      way1 [IBUF_WAY_DEPTH];
  logic [IBUF_PTR_W-1:0] head0;
  logic [IBUF_PTR_W-1:0] head1;
  logic [IBUF_PTR_W-1:0] tail0;
  logic [IBUF_PTR_W-1:0] tail1;
  logic                  head_way;
  logic                  tail_way;
  logic [IBUF_LEN_W-1:0] length;
  logic [UOP_W-1:0]      in_a;
  logic [UOP_W-1:0]      in_b;
  logic [UOP_W-1:0]      out_a;
  logic [UOP_W-1:0]      out_b;

  assign in_a = {i_a_pc, i_a_alu_op, i_a_wr_en, i_a_dest,
                 i_a_rs1, i_a_rs2, i_a_src2_is_imm, i_a_imm};
  assign in_b = {i_b_pc, i_b_alu_op, i_b_wr_en, i_b_dest,
                 i_b_rs1, i_b_rs2, i_b_src2_is_imm, i_b_imm};

  // head_way names the bank holding the oldest entry
  assign out_a = head_way ? way1[head1] : way0[head0];
  assign out_b = head_way ? way0[head0] : way1[head1];

  assign {o_a_pc, o_a_alu_op, o_a_wr_en, o_a_dest,
          o_a_rs1, o_a_rs2, o_a_src2_is_imm, o_a_imm} = out_a;
  assign {o_b_pc, o_b_alu_op, o_b_wr_en, o_b_dest,
          o_b_rs1, o_b_rs2, o_b_src2_is_imm, o_b_imm} = out_b;

  assign o_a_valid = (length >= IBUF_LEN_W'(1));
  assign o_b_valid = (length >= IBUF_LEN_W'(2));
  assign o_ready   = (length <= IBUF_LEN_W'(IBUF_READY_MAX));

  ////////////////////
  // pointers and length
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_rst || i_flush) begin
      head0    <= '0;
      head1    <= '0;
      tail0    <= '0;
      tail1    <= '0;
      head_way <= 1'b0;
      tail_way <= 1'b0;
      length   <= '0;
    end else begin
      // a pair advances both banks, a single only the current one
      if ((!tail_way && i_size == 2'd1) || i_size == 2'd2) tail0 <= tail0 + 1'b1;
      if ((tail_way && i_size == 2'd1) || i_size == 2'd2) tail1 <= tail1 + 1'b1;
      if ((!head_way && i_take == 2'd1) || i_take == 2'd2) head0 <= head0 + 1'b1;
      if ((head_way && i_take == 2'd1) || i_take == 2'd2) head1 <= head1 + 1'b1;
      tail_way <= tail_way ^ i_size[0];
      head_way <= head_way ^ i_take[0];
      length   <= length + IBUF_LEN_W'(i_size) - IBUF_LEN_W'(i_take);
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_size == 2'd1 || i_size == 2'd2) begin
      if (tail_way) way1[tail1] <= in_a;
      else way0[tail0] <= in_a;
    end
    if (i_size == 2'd2) begin
      if (tail_way) way0[tail0] <= in_b;
      else way1[tail1] <= in_b;
    end
  end

endmodule

// File: hw/dual_execute.sv
`timescale 1ns/1ps

module dual_execute
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_flush,
  input  logic        i_a_valid,
  input  logic [3:0]  i_a_alu_op,
  input  logic        i_a_wr_en,
  input  logic [4:0]  i_a_dest,
  input  logic [4:0]  i_a_rs1,
  input  logic [4:0]  i_a_rs2,
  input  logic        i_a_src2_is_imm,
  input  logic [31:0] i_a_imm,
  input  logic        i_b_valid,
  input  logic [3:0]  i_b_alu_op,
  input  logic        i_b_wr_en,
  input  logic [4:0]  i_b_dest,
  input  logic [4:0]  i_b_rs1,
  input  logic [4:0]  i_b_rs2,
  input  logic        i_b_src2_is_imm,
  input  logic [31:0] i_b_imm,
  input  logic [31:0] i_rd_data0,
  input  logic [31:0] i_rd_data1,
  input  logic [31:0] i_rd_data2,
  input  logic [31:0] i_rd_data3,
  output logic [1:0]  o_take,
  output logic [4:0]  o_rd_addr0,
  output logic [4:0]  o_rd_addr1,
  output logic [4:0]  o_rd_addr2,
  output logic [4:0]  o_rd_addr3,
  output logic        o_ex_a_valid,
  output logic [4:0]  o_ex_a_dest,
  output logic [31:0] o_ex_a_data,
  output logic        o_ex_b_valid,
  output logic [4:0]  o_ex_b_dest,
  output logic [31:0] o_ex_b_data
);

  logic        hazard;
  logic        issue_b;
  logic [31:0] a_src1;
  logic [31:0] a_src2;
  logic [31:0] b_src1;
  logic [31:0] b_src2;

  // newest value first: own result register, then the register file
  function automatic logic [31:0] operand(input logic [4:0] addr, input logic [31:0] rf);
    if (addr == 5'd0) return 32'd0;
    if (o_ex_b_valid && o_ex_b_dest == addr) return o_ex_b_data;
    if (o_ex_a_valid && o_ex_a_dest == addr) return o_ex_a_data;
    return rf;
  endfunction

  function automatic logic [31:0] alu(input logic [3:0] op, input logic [31:0] x,
                                      input logic [31:0] y);
    case (op)
      ALU_ADD: return x + y;
      ALU_SUB: return x - y;
      ALU_AND: return x & y;
      ALU_OR:  return x | y;
      ALU_XOR: return x ^ y;
      ALU_SLL: return x << y[4:0];
      ALU_SRL: return x >> y[4:0];
      ALU_SLT: return {31'd0, $signed(x) < $signed(y)};
      ALU_LUI: return y;
      default: return 32'd0;
    endcase
  endfunction

  ////////////////////
  // issue
  ////////////////////

  // b cannot see a's result in the same cycle
  assign hazard = i_a_wr_en && (i_b_rs1 == i_a_dest ||
                                (!i_b_src2_is_imm && i_b_rs2 == i_a_dest));
  assign issue_b = i_a_valid && i_b_valid && !hazard;
  assign o_take  = {issue_b, i_a_valid && !issue_b};

  assign o_rd_addr0 = i_a_rs1;
  assign o_rd_addr1 = i_a_rs2;
  assign o_rd_addr2 = i_b_rs1;
  assign o_rd_addr3 = i_b_rs2;

  always_comb begin
    a_src1 = operand(i_a_rs1, i_rd_data0);
    a_src2 = i_a_src2_is_imm ? i_a_imm : operand(i_a_rs2, i_rd_data1);
    b_src1 = operand(i_b_rs1, i_rd_data2);
    b_src2 = i_b_src2_is_imm ? i_b_imm : operand(i_b_rs2, i_rd_data3);
  end

  ////////////////////
  // result register
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_rst || i_flush) begin
      o_ex_a_valid <= 1'b0;
      o_ex_b_valid <= 1'b0;
    end else begin
      o_ex_a_valid <= i_a_valid && i_a_wr_en;
      o_ex_b_valid <= issue_b && i_b_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    o_ex_a_dest <= i_a_dest;
    o_ex_a_data <= alu(i_a_alu_op, a_src1, a_src2);
    o_ex_b_dest <= i_b_dest;
    o_ex_b_data <= alu(i_b_alu_op, b_src1, b_src2);
  end

endmodule

// File: hw/result_regfile.sv
`timescale 1ns/1ps

module result_regfile (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_ex_a_valid,
  input  logic [4:0]  i_ex_a_dest,
  input  logic [31:0] i_ex_a_data,
  input  logic        i_ex_b_valid,
  input  logic [4:0]  i_ex_b_dest,
  input  logic [31:0] i_ex_b_data,
  input  logic [4:0]  i_rd_addr0,
  input  logic [4:0]  i_rd_addr1,
  input  logic [4:0]  i_rd_addr2,
  input  logic [4:0]  i_rd_addr3,
  output logic [31:0] o_rd_data0,
  output logic [31:0] o_rd_data1,
  output logic [31:0] o_rd_data2,
  output logic [31:0] o_rd_data3,
  output logic        o_wb_a_valid,
  output logic [4:0]  o_wb_a_dest,
  output logic [31:0] o_wb_a_data,
  output logic        o_wb_b_valid,
  output logic [4:0]  o_wb_b_dest,
  output logic [31:0] o_wb_b_data
);

  logic [31:0] regs [32];

  assign o_rd_data0 = regs[i_rd_addr0];
  assign o_rd_data1 = regs[i_rd_addr1];
  assign o_rd_data2 = regs[i_rd_addr2];
  assign o_rd_data3 = regs[i_rd_addr3];

  // b is younger, so its write lands last
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int k = 0; k < 32; k++) regs[k] <= 32'd0;
    end else begin
      if (i_ex_a_valid) regs[i_ex_a_dest] <= i_ex_a_data;
      if (i_ex_b_valid) regs[i_ex_b_dest] <= i_ex_b_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_wb_a_valid <= 1'b0;
      o_wb_b_valid <= 1'b0;
    end else begin
      o_wb_a_valid <= i_ex_a_valid;
      o_wb_b_valid <= i_ex_b_valid;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_a_dest <= i_ex_a_dest;
    o_wb_a_data <= i_ex_a_data;
    o_wb_b_dest <= i_ex_b_dest;
    o_wb_b_data <= i_ex_b_data;
  end

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_flush,
  input  logic [1:0]  i_size,
  input  logic [31:0] i_a_pc,
  input  logic [31:0] i_a_insn,
  input  logic [31:0] i_b_pc,
  input  logic [31:0] i_b_insn,
  output logic        o_ready,
  output logic        o_wb_a_valid,
  output logic [4:0]  o_wb_a_dest,
  output logic [31:0] o_wb_a_data,
  output logic        o_wb_b_valid,
  output logic [4:0]  o_wb_b_dest,
  output logic [31:0] o_wb_b_data
);

  ////////////////////
  // decode to buffer
  ////////////////////

  logic [1:0]  d_size;
  logic [31:0] d_a_pc;
  logic [3:0]  d_a_alu_op;
  logic        d_a_wr_en;
  logic [4:0]  d_a_dest;
  logic [4:0]  d_a_rs1;
  logic [4:0]  d_a_rs2;
  logic        d_a_src2_is_imm;
  logic [31:0] d_a_imm;
  logic [31:0] d_b_pc;
  logic [3:0]  d_b_alu_op;
  logic        d_b_wr_en;
  logic [4:0]  d_b_dest;
  logic [4:0]  d_b_rs1;
  logic [4:0]  d_b_rs2;
  logic        d_b_src2_is_imm;
  logic [31:0] d_b_imm;

  // buffer head to execute
  logic        q_a_valid;
  logic [3:0]  q_a_alu_op;
  logic        q_a_wr_en;
  logic [4:0]  q_a_dest;
  logic [4:0]  q_a_rs1;
  logic [4:0]  q_a_rs2;
  logic        q_a_src2_is_imm;
  logic [31:0] q_a_imm;
  logic        q_b_valid;
  logic [3:0]  q_b_alu_op;
  logic        q_b_wr_en;
  logic [4:0]  q_b_dest;
  logic [4:0]  q_b_rs1;
  logic [4:0]  q_b_rs2;
  logic        q_b_src2_is_imm;
  logic [31:0] q_b_imm;
  logic [1:0]  take;

  // execute and register file
  logic [4:0]  rd_addr0;
  logic [4:0]  rd_addr1;
  logic [4:0]  rd_addr2;
  logic [4:0]  rd_addr3;
  logic [31:0] rd_data0;
  logic [31:0] rd_data1;
  logic [31:0] rd_data2;
  logic [31:0] rd_data3;
  logic        ex_a_valid;
  logic [4:0]  ex_a_dest;
  logic [31:0] ex_a_data;
  logic        ex_b_valid;
  logic [4:0]  ex_b_dest;
  logic [31:0] ex_b_data;

  insn_decode insn_decode_inst (
    .clk(clk), .i_rst(i_rst), .i_flush(i_flush), .i_size(i_size),
    .i_a_pc(i_a_pc), .i_a_insn(i_a_insn), .i_b_pc(i_b_pc), .i_b_insn(i_b_insn),
    .o_size(d_size),
    .o_a_pc(d_a_pc), .o_a_alu_op(d_a_alu_op), .o_a_wr_en(d_a_wr_en), .o_a_dest(d_a_dest),
    .o_a_rs1(d_a_rs1), .o_a_rs2(d_a_rs2), .o_a_src2_is_imm(d_a_src2_is_imm),
    .o_a_imm(d_a_imm),
    .o_b_pc(d_b_pc), .o_b_alu_op(d_b_alu_op), .o_b_wr_en(d_b_wr_en), .o_b_dest(d_b_dest),
    .o_b_rs1(d_b_rs1), .o_b_rs2(d_b_rs2), .o_b_src2_is_imm(d_b_src2_is_imm),
    .o_b_imm(d_b_imm)
  );

  // pc rides along in the buffer but execute has no use for it
  insn_buffer insn_buffer_inst (
    .clk(clk), .i_rst(i_rst), .i_flush(i_flush), .i_size(d_size),
    .i_a_pc(d_a_pc), .i_a_alu_op(d_a_alu_op), .i_a_wr_en(d_a_wr_en), .i_a_dest(d_a_dest),
    .i_a_rs1(d_a_rs1), .i_a_rs2(d_a_rs2), .i_a_src2_is_imm(d_a_src2_is_imm),
    .i_a_imm(d_a_imm),
    .i_b_pc(d_b_pc), .i_b_alu_op(d_b_alu_op), .i_b_wr_en(d_b_wr_en), .i_b_dest(d_b_dest),
    .i_b_rs1(d_b_rs1), .i_b_rs2(d_b_rs2), .i_b_src2_is_imm(d_b_src2_is_imm),
    .i_b_imm(d_b_imm),
    .i_take(take), .o_ready(o_ready),
    .o_a_valid(q_a_valid), .o_a_pc(), .o_a_alu_op(q_a_alu_op), .o_a_wr_en(q_a_wr_en),
    .o_a_dest(q_a_dest), .o_a_rs1(q_a_rs1), .o_a_rs2(q_a_rs2),
    .o_a_src2_is_imm(q_a_src2_is_imm), .o_a_imm(q_a_imm),
    .o_b_valid(q_b_valid), .o_b_pc(), .o_b_alu_op(q_b_alu_op), .o_b_wr_en(q_b_wr_en),
    .o_b_dest(q_b_dest), .o_b_rs1(q_b_rs1), .o_b_rs2(q_b_rs2),
    .o_b_src2_is_imm(q_b_src2_is_imm), .o_b_imm(q_b_imm)
  );

  dual_execute dual_execute_inst (
    .clk(clk), .i_rst(i_rst), .i_flush(i_flush),
    .i_a_valid(q_a_valid), .i_a_alu_op(q_a_alu_op), .i_a_wr_en(q_a_wr_en),
    .i_a_dest(q_a_dest), .i_a_rs1(q_a_rs1), .i_a_rs2(q_a_rs2),
    .i_a_src2_is_imm(q_a_src2_is_imm), .i_a_imm(q_a_imm),
    .i_b_valid(q_b_valid), .i_b_alu_op(q_b_alu_op), .i_b_wr_en(q_b_wr_en),
    .i_b_dest(q_b_dest), .i_b_rs1(q_b_rs1), .i_b_rs2(q_b_rs2),
    .i_b_src2_is_imm(q_b_src2_is_imm), .i_b_imm(q_b_imm),
    .i_rd_data0(rd_data0), .i_rd_data1(rd_data1),
    .i_rd_data2(rd_data2), .i_rd_data3(rd_data3),
    .o_take(take),
    .o_rd_addr0(rd_addr0), .o_rd_addr1(rd_addr1),
    .o_rd_addr2(rd_addr2), .o_rd_addr3(rd_addr3),
    .o_ex_a_valid(ex_a_valid), .o_ex_a_dest(ex_a_dest), .o_ex_a_data(ex_a_data),
    .o_ex_b_valid(ex_b_valid), .o_ex_b_dest(ex_b_dest), .o_ex_b_data(ex_b_data)
  );

  result_regfile result_regfile_inst (
    .clk(clk), .i_rst(i_rst),
    .i_ex_a_valid(ex_a_valid), .i_ex_a_dest(ex_a_dest), .i_ex_a_data(ex_a_data),
    .i_ex_b_valid(ex_b_valid), .i_ex_b_dest(ex_b_dest), .i_ex_b_data(ex_b_data),
    .i_rd_addr0(rd_addr0), .i_rd_addr1(rd_addr1),
    .i_rd_addr2(rd_addr2), .i_rd_addr3(rd_addr3),
    .o_rd_data0(rd_data0), .o_rd_data1(rd_data1),
    .o_rd_data2(rd_data2), .o_rd_data3(rd_data3),
    .o_wb_a_valid(o_wb_a_valid), .o_wb_a_dest(o_wb_a_dest), .o_wb_a_data(o_wb_a_data),
    .o_wb_b_valid(o_wb_b_valid), .o_wb_b_dest(o_wb_b_dest), .o_wb_b_data(o_wb_b_data)
  );

endmodule

// File: tests/core_asserts.sv
`timescale 1ns/1ps

module core_asserts (
  input logic       clk,
  input logic       i_rst,
  input logic       i_flush,
  input logic [4:0] i_len,
  input logic [1:0] i_take,
  input logic       i_a_valid,
  input logic       i_b_valid,
  input logic       i_ex_a_valid,
  input logic       i_ex_b_valid
);

  ////////////////////
  // buffer
  ////////////////////

  // two ways of 8
  assert property (@(posedge clk) disable iff (i_rst) i_len <= 5'd16)
    else $error("buffer length %0d is above 16", i_len);

  // execute never consumes an empty head slot
  assert property (@(posedge clk) disable iff (i_rst)
    i_take <= {1'b0, i_a_valid} + {1'b0, i_b_valid})
    else $error("issue count %0d exceeds valid head entries", i_take);

  ////////////////////
  // execute
  ////////////////////

  assert property (@(posedge clk) disable iff (i_rst)
    i_flush |=> !i_ex_a_valid && !i_ex_b_valid)
    else $error("execute result still valid after a flush");

endmodule

bind insn_buffer core_asserts buffer_asserts (
  .clk(clk), .i_rst(i_rst), .i_flush(i_flush), .i_len(length), .i_take(i_take),
  .i_a_valid(o_a_valid), .i_b_valid(o_b_valid),
  .i_ex_a_valid(1'b0), .i_ex_b_valid(1'b0)
);

bind dual_execute core_asserts execute_asserts (
  .clk(clk), .i_rst(i_rst), .i_flush(i_flush), .i_len(5'd0), .i_take(o_take),
  .i_a_valid(i_a_valid), .i_b_valid(i_b_valid),
  .i_ex_a_valid(o_ex_a_valid), .i_ex_b_valid(o_ex_b_valid)
);

// File: tests/core_tb.sv
`timescale 1ns/1ps

module core_tb
  import core_pkg::*;
();

  localparam int MAX_ROWS = 64;

  logic        clk;
  logic        i_rst;
  logic        i_flush;
  logic [1:0]  i_size;
  logic [31:0] i_a_pc;
  logic [31:0] i_a_insn;
  logic [31:0] i_b_pc;
  logic [31:0] i_b_insn;
  logic        o_ready;
  logic        o_wb_a_valid;
  logic [4:0]  o_wb_a_dest;
  logic [31:0] o_wb_a_data;
  logic        o_wb_b_valid;
  logic [4:0]  o_wb_b_dest;
  logic [31:0] o_wb_b_data;

  // stimulus table, one row per fetch cycle
  int          n_rows;
  int          row_test  [MAX_ROWS];
  logic [1:0]  row_size  [MAX_ROWS];
  insn_word_u  row_a     [MAX_ROWS];
  insn_word_u  row_b     [MAX_ROWS];
  logic        row_flush [MAX_ROWS];

  // reference registers and the reports still to come
  logic [31:0] model_regs [32];
  logic [31:0] seen_regs  [32];
  logic [4:0]  exp_dest   [$];
  logic [31:0] exp_data   [$];

  int          cycles;
  int          cycle_limit;
  int          errors;
  int          test_errors;
  int          checks;
  int          tests_done;
  logic        saw_not_ready;
  logic [31:0] next_pc;

  core_top core_top_inst (
    .clk(clk), .i_rst(i_rst), .i_flush(i_flush), .i_size(i_size),
    .i_a_pc(i_a_pc), .i_a_insn(i_a_insn), .i_b_pc(i_b_pc), .i_b_insn(i_b_insn),
    .o_ready(o_ready),
    .o_wb_a_valid(o_wb_a_valid), .o_wb_a_dest(o_wb_a_dest), .o_wb_a_data(o_wb_a_data),
    .o_wb_b_valid(o_wb_b_valid), .o_wb_b_dest(o_wb_b_dest), .o_wb_b_data(o_wb_b_data)
  );

  always #50 clk = ~clk;

  function automatic insn_word_u rtype_word(input logic [10:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    insn_word_u w;
    w.r.op    = OP_RTYPE;
    w.r.rd    = rd;
    w.r.rs1   = rs1;
    w.r.rs2   = rs2;
    w.r.funct = fn;
    return w;
  endfunction

  function automatic insn_word_u itype_word(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [15:0] imm);
    insn_word_u w;
    w.i.op  = op;
    w.i.rd  = rd;
    w.i.rs1 = rs1;
    w.i.imm = imm;
    return w;
  endfunction

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  task automatic add_row(input int test, input logic [1:0] size, input insn_word_u a,
                         input insn_word_u b, input logic flush);
    row_test[n_rows]  = test;
    row_size[n_rows]  = size;
    row_a[n_rows]     = a;
    row_b[n_rows]     = b;
    row_flush[n_rows] = flush;
    n_rows++;
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic build_table();
    insn_word_u junk;
    n_rows = 0;
    for (int k = 0; k < 2; k++) begin
      add_row(2, 2'd2, itype_word(OP_ADDI, 5'd1, 5'd0, rand16()),
              itype_word(OP_ADDI, 5'd2, 5'd0, rand16()), 1'b0);
      add_row(2, 2'd2, itype_word(OP_ADDI, 5'd3, 5'd0, rand16()),
              itype_word(OP_ADDI, 5'd4, 5'd1, rand16()), 1'b0);
      add_row(2, 2'd2, rtype_word(FN_ADD, 5'd5, 5'd1, 5'd2),
              rtype_word(FN_SUB, 5'd6, 5'd4, 5'd3), 1'b0);
      add_row(2, 2'd2, rtype_word(FN_AND, 5'd7, 5'd1, 5'd4),
              rtype_word(FN_OR, 5'd8, 5'd2, 5'd3), 1'b0);
      // single word, b carries noise that must be ignored
      junk = $urandom;
      add_row(2, 2'd1, rtype_word(FN_XOR, 5'd9, 5'd4, 5'd2), junk, 1'b0);
      add_row(2, 2'd2, rtype_word(FN_SLL, 5'd10, 5'd4, 5'd3),
              rtype_word(FN_SRL, 5'd11, 5'd4, 5'd1), 1'b0);
      add_row(2, 2'd2, rtype_word(FN_SLT, 5'd12, 5'd1, 5'd2),
              rtype_word(FN_SLT, 5'd13, 5'd2, 5'd1), 1'b0);
    end

    add_row(3, 2'd2, itype_word(OP_ADDI, 5'd14, 5'd0, 16'hfff0),
            itype_word(OP_ANDI, 5'd15, 5'd4, 16'h8f0f), 1'b0);
    add_row(3, 2'd2, itype_word(OP_ORI, 5'd16, 5'd1, 16'h8001),
            itype_word(OP_XORI, 5'd17, 5'd2, 16'hffff), 1'b0);
    add_row(3, 2'd2, itype_word(OP_LUI, 5'd18, 5'd7, rand16()),
            itype_word(OP_ORI, 5'd19, 5'd18, 16'h1234), 1'b0);
    add_row(3, 2'd2, itype_word(OP_ADDI, 5'd0, 5'd1, 16'd5),
            itype_word(6'h3f, 5'd20, 5'd1, 16'd1), 1'b0);
    add_row(3, 2'd2, rtype_word(11'd9, 5'd21, 5'd1, 5'd2),
            rtype_word(FN_ADD, 5'd22, 5'd0, 5'd1), 1'b0);

    add_row(4, 2'd2, itype_word(OP_ADDI, 5'd20, 5'd0, 16'd7),
            rtype_word(FN_ADD, 5'd21, 5'd20, 5'd20), 1'b0);
    add_row(4, 2'd2, itype_word(OP_XORI, 5'd22, 5'd1, 16'h0055),
            rtype_word(FN_SUB, 5'd23, 5'd2, 5'd22), 1'b0);
    add_row(4, 2'd2, itype_word(OP_ADDI, 5'd24, 5'd21, 16'd1),
            itype_word(OP_ADDI, 5'd25, 5'd24, 16'd1), 1'b0);
    add_row(4, 2'd2, rtype_word(FN_ADD, 5'd26, 5'd25, 5'd24),
            rtype_word(FN_SLL, 5'd27, 5'd26, 5'd20), 1'b0);
    add_row(4, 2'd2, itype_word(OP_ADDI, 5'd28, 5'd0, 16'd1),
            itype_word(OP_ADDI, 5'd28, 5'd0, 16'd2), 1'b0);
    add_row(4, 2'd2, rtype_word(FN_ADD, 5'd29, 5'd28, 5'd28),
            rtype_word(FN_XOR, 5'd30, 5'd23, 5'd27), 1'b0);

    // each word reads the one before it, so one issues per cycle and the buffer grows
    for (int k = 0; k < 20; k++) begin
      add_row(5, 2'd2, itype_word(OP_ADDI, 5'd1, 5'd2, 16'(k + 1)),
              rtype_word(FN_ADD, 5'd2, 5'd2, 5'd1), 1'b0);
    end

    for (int k = 0; k < 4; k++) begin
      add_row(6, 2'd2, itype_word(OP_ADDI, 5'd3, 5'd3, 16'd3),
              rtype_word(FN_ADD, 5'd4, 5'd4, 5'd3), 1'b0);
    end
    add_row(6, 2'd0, '0, '0, 1'b1);
    add_row(6, 2'd2, rtype_word(FN_ADD, 5'd5, 5'd3, 5'd4),
            rtype_word(FN_XOR, 5'd6, 5'd4, 5'd3), 1'b0);
    add_row(6, 2'd2, itype_word(OP_ADDI, 5'd3, 5'd3, 16'd1),
            rtype_word(FN_ADD, 5'd7, 5'd3, 5'd5), 1'b0);
  endtask

  ////////////////////
  // reference model
  ////////////////////

  task automatic model_apply(input insn_word_u w);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] sext;
    logic [31:0] res;
    logic        wr;
    x    = model_regs[w.i.rs1];
    y    = model_regs[w.r.rs2];
    sext = {{16{w.i.imm[15]}}, w.i.imm};
    res  = 32'd0;
    wr   = 1'b1;
    if (w.r.op == OP_RTYPE) begin
      case (w.r.funct)
        FN_ADD:  res = x + y;
        FN_SUB:  res = x - y;
        FN_AND:  res = x & y;
        FN_OR:   res = x | y;
        FN_XOR:  res = x ^ y;
        FN_SLL:  res = x << y[4:0];
        FN_SRL:  res = x >> y[4:0];
        FN_SLT:  res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        default: wr = 1'b0;
      endcase
    end else begin
      case (w.i.op)
        OP_ADDI: res = x + sext;
        OP_ANDI: res = x & sext;
        OP_ORI:  res = x | sext;
        OP_XORI: res = x ^ sext;
        OP_LUI:  res = {w.i.imm, 16'd0};
        default: wr = 1'b0;
      endcase
    end
    if (wr && w.i.rd != 5'd0) begin
      model_regs[w.i.rd] = res;
      exp_dest.push_back(w.i.rd);
      exp_data.push_back(res);
    end
  endtask

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_port(input string name, input logic valid, input logic [4:0] dest,
                            input logic [31:0] data);
    logic [4:0]  want_dest;
    logic [31:0] want_data;
    if (valid === 1'b1) begin
      checks++;
      if (exp_dest.size() == 0) begin
        $display("ERROR: %s reported r%0d = %h at %0t with nothing outstanding",
                 name, dest, data, $time);
        count_error();
      end else begin
        want_dest = exp_dest.pop_front();
        want_data = exp_data.pop_front();
        if (dest !== want_dest) begin
          $display("[FAIL] %0t: %s_dest expected %0d got %0d", $time, name, want_dest, dest);
          count_error();
        end
        if (data !== want_data) begin
          $display("[FAIL] %0t: %s_data expected %h got %h", $time, name, want_data, data);
          count_error();
        end
        // registers as reported so far
        seen_regs[want_dest] = want_data;
      end
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    cycles++;
    if (cycles > cycle_limit) begin
      $display("ERROR: run passed %0d cycles without finishing the reports", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end else begin
      check_port("o_wb_a", o_wb_a_valid, o_wb_a_dest, o_wb_a_data);
      check_port("o_wb_b", o_wb_b_valid, o_wb_b_dest, o_wb_b_data);
      if (!o_ready) saw_not_ready = 1'b1;
    end
  endtask

  task automatic apply_row(input int r);
    if (row_flush[r]) begin
      i_size  = 2'd0;
      i_flush = 1'b1;
      next_cycle();
      i_flush = 1'b0;
      // results registered before the flush edge reported just now, the rest is gone
      exp_dest.delete();
      exp_data.delete();
      for (int k = 0; k < 32; k++) model_regs[k] = seen_regs[k];
    end else begin
      while (!o_ready) begin
        i_size = 2'd0;
        next_cycle();
      end
      i_size   = row_size[r];
      i_a_insn = row_a[r];
      i_b_insn = row_b[r];
      i_a_pc   = next_pc;
      i_b_pc   = next_pc + 32'd4;
      next_pc  = next_pc + 32'd8;
      if (row_size[r] != 2'd0) model_apply(row_a[r]);
      if (row_size[r] == 2'd2) model_apply(row_b[r]);
      next_cycle();
    end
  endtask

  task automatic run_rows(input int test);
    test_errors = 0;
    for (int r = 0; r < n_rows; r++) begin
      if (row_test[r] == test) apply_row(r);
    end
    i_size = 2'd0;
    while (exp_dest.size() != 0) next_cycle();
    repeat (3) next_cycle();
  endtask

  task automatic report_test(input int test, input string name);
    tests_done++;
    if (test_errors == 0) $display("test %0d %s: ok", test, name);
    else $display("test %0d %s: %0d errors", test, name, test_errors);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    clk           = 1'b0;
    i_rst         = 1'b1;
    i_flush       = 1'b0;
    i_size        = 2'd0;
    i_a_pc        = 32'd0;
    i_a_insn      = 32'd0;
    i_b_pc        = 32'd0;
    i_b_insn      = 32'd0;
    cycles        = 0;
    errors        = 0;
    test_errors   = 0;
    checks        = 0;
    tests_done    = 0;
    saw_not_ready = 1'b0;
    next_pc       = 32'h0000_1000;
    void'($urandom(24));
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = 32'd0;
      seen_regs[k]  = 32'd0;
    end
    build_table();
    cycle_limit = 4 * n_rows + 50;

    repeat (10) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;

    if (o_ready !== 1'b1) begin
      $display("[FAIL] %0t: o_ready expected 1 got %b", $time, o_ready);
      count_error();
    end
    if (o_wb_a_valid !== 1'b0) begin
      $display("[FAIL] %0t: o_wb_a_valid expected 0 got %b", $time, o_wb_a_valid);
      count_error();
    end
    if (o_wb_b_valid !== 1'b0) begin
      $display("[FAIL] %0t: o_wb_b_valid expected 0 got %b", $time, o_wb_b_valid);
      count_error();
    end
    report_test(1, "reset state");

    run_rows(2);
    report_test(2, "r-format operations");
    run_rows(3);
    report_test(3, "i-format operations");
    run_rows(4);
    report_test(4, "dependent pairs");
    saw_not_ready = 1'b0;
    run_rows(5);
    if (!saw_not_ready) begin
      $display("ERROR: o_ready never fell while the buffer was filling");
      count_error();
    end
    report_test(5, "buffer fill");
    run_rows(6);
    report_test(6, "flush");

    $display("%0d tests, %0d reports checked, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/core_pkg.sv
hw/insn_decode.sv
hw/insn_buffer.sv
hw/dual_execute.sv
hw/result_regfile.sv
hw/core_top.sv
tests/core_asserts.sv
tests/core_tb.sv

// File: Makefile
# Verilator build for the dual-issue core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
